// ==== src/video_pkg.sv ====
`default_nettype none

package video_pkg;

   // Line and frame timing in vga_clk cycles
   localparam int H_TOTAL      = 40;
   localparam int H_ACTIVE     = 32;
   localparam int H_SYNC_START = 34;
   localparam int H_SYNC_END   = 38;
   localparam int V_TOTAL      = 24;
   localparam int V_SYNC_LINE  = 0;
   localparam int V_PF_START   = 5;
   localparam int V_PF_END     = 21;

   // Source playfield in external memory
   localparam int SRC_W     = 16;
   localparam int SRC_LINES = 16;

   // Vertical repeat of each source line
   localparam int LINE_REP_X2 = 2;
   localparam int LINE_REP_X4 = 4;

   typedef logic [5:0] h_count_t;
   typedef logic [4:0] v_count_t;
   typedef logic [7:0] pixel_t;
   typedef logic [$clog2(SRC_W)-1:0] src_x_t;
   typedef logic [$clog2(SRC_LINES)-1:0] src_line_t;
   typedef logic [$clog2(SRC_LINES*SRC_W)-1:0] src_addr_t;

   localparam pixel_t BLANK_PIX = 8'h00;

   typedef enum logic [1:0] {
      SCHED_HOLD,
      SCHED_IDLE,
      SCHED_RUN
   } sched_state_t;

   typedef enum logic [1:0] {
      FETCH_IDLE,
      FETCH_BUS,
      FETCH_DONE
   } fetch_state_t;

endpackage

`default_nettype wire

// ==== src/video_timing.sv ====
`default_nettype none

module video_timing (
   input  wire                  vga_clk,
   input  wire                  reset_n,
   output video_pkg::h_count_t  x_cnt,
   output video_pkg::v_count_t  y_cnt,
   output logic                 line_end,
   output logic                 active,
   output logic                 hsync,
   output logic                 vsync,
   output logic                 pf
);
   import video_pkg::*;

   always_ff @(posedge vga_clk) begin
      if (!reset_n) begin
         x_cnt <= '0;
         y_cnt <= '0;
      end else if (line_end) begin
         x_cnt <= '0;
         if (y_cnt == v_count_t'(V_TOTAL - 1)) begin
            y_cnt <= '0;
         end else begin
            y_cnt <= y_cnt + 1'b1;
         end
      end else begin
         x_cnt <= x_cnt + 1'b1;
      end
   end

   assign line_end = (x_cnt == h_count_t'(H_TOTAL - 1));

   // Visible part of every line, rows outside the playfield included
   assign active = (x_cnt < h_count_t'(H_ACTIVE));

   assign hsync = (x_cnt >= h_count_t'(H_SYNC_START)) && (x_cnt < h_count_t'(H_SYNC_END));
   assign vsync = (y_cnt == v_count_t'(V_SYNC_LINE));

   // Lines that show source pixels
   assign pf = (y_cnt >= v_count_t'(V_PF_START)) && (y_cnt < v_count_t'(V_PF_END));

endmodule

`default_nettype wire

// ==== src/line_render.sv ====
`default_nettype none

module line_render (
   input  wire                       vga_clk,
   input  wire                       reset_n,
   input  wire video_pkg::v_count_t  y_cnt,
   input  wire                       line_end,
   input  wire                       scale_x4,
   output logic                      render_start,
   output logic                      render_buffer,
   output video_pkg::src_line_t      render_line,
   output logic                      output_buffer
);
   import video_pkg::*;

   sched_state_t render_state;
   sched_state_t output_state;
   logic [1:0]   render_phase;
   logic [1:0]   output_phase;
   logic         scale_q;
   logic         mode_change;
   logic [1:0]   phase_last;
   v_count_t     render_arm_line;
   v_count_t     render_stop_line;
   logic         frame_end;

   assign mode_change = (scale_x4 != scale_q);
   assign frame_end   = (y_cnt == v_count_t'(V_TOTAL - 1));
   assign phase_last  = scale_x4 ? 2'(LINE_REP_X4 - 1) : 2'(LINE_REP_X2 - 1);

   // Line 0 is fetched R+1 lines ahead of the playfield
   assign render_arm_line  = scale_x4 ? v_count_t'(V_PF_START - LINE_REP_X4 - 1)
                                      : v_count_t'(V_PF_START - LINE_REP_X2 - 1);
   assign render_stop_line = scale_x4 ? v_count_t'(V_PF_END - LINE_REP_X4 - 1)
                                      : v_count_t'(V_PF_END - LINE_REP_X2 - 1);

   // Fill side: picks source line and bank, pulses the fetch
   always_ff @(posedge vga_clk) begin
      if (!reset_n) begin
         scale_q       <= scale_x4;
         render_state  <= SCHED_IDLE;
         render_phase  <= '0;
         render_start  <= 1'b0;
         render_buffer <= 1'b0;
         render_line   <= '0;
      end else begin
         scale_q      <= scale_x4;
         render_start <= 1'b0;
         if (mode_change) begin
            render_state <= SCHED_HOLD;
         end else if (line_end) begin
            case (render_state)
               SCHED_HOLD: begin
                  if (frame_end) begin
                     render_state <= SCHED_IDLE;
                  end
               end
               SCHED_IDLE: begin
                  if (y_cnt == render_arm_line) begin
                     render_state  <= SCHED_RUN;
                     render_phase  <= '0;
                     render_start  <= 1'b1;
                     render_buffer <= 1'b0;
                     render_line   <= '0;
                  end
               end
               SCHED_RUN: begin
                  if (y_cnt == render_stop_line) begin
                     render_state <= SCHED_IDLE;
                  end else if (render_phase == phase_last) begin
                     render_phase  <= '0;
                     render_start  <= 1'b1;
                     render_buffer <= ~render_buffer;
                     render_line   <= render_line + 1'b1;
                  end else begin
                     render_phase <= render_phase + 1'b1;
                  end
               end
               default: render_state <= SCHED_IDLE;
            endcase
         end
      end
   end

   // Display side: bank k is shown from line V_PF_START + k*R
   always_ff @(posedge vga_clk) begin
      if (!reset_n) begin
         output_state  <= SCHED_IDLE;
         output_phase  <= '0;
         output_buffer <= 1'b0;
      end else if (mode_change) begin
         output_state <= SCHED_HOLD;
      end else if (line_end) begin
         case (output_state)
            SCHED_HOLD: begin
               if (frame_end) begin
                  output_state <= SCHED_IDLE;
               end
            end
            SCHED_IDLE: begin
               if (y_cnt == v_count_t'(V_PF_START - 1)) begin
                  output_state  <= SCHED_RUN;
                  output_phase  <= '0;
                  output_buffer <= 1'b0;
               end
            end
            SCHED_RUN: begin
               if (y_cnt == v_count_t'(V_PF_END - 1)) begin
                  output_state <= SCHED_IDLE;
               end else if (output_phase == phase_last) begin
                  output_phase  <= '0;
                  output_buffer <= ~output_buffer;
               end else begin
                  output_phase <= output_phase + 1'b1;
               end
            end
            default: output_state <= SCHED_IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== src/line_fetch.sv ====
`default_nettype none

module line_fetch (
   input  wire                        vga_clk,
   input  wire                        reset_n,
   input  wire                        render_start,
   input  wire                        render_buffer,
   input  wire video_pkg::src_line_t  render_line,
   output logic                       wb_cyc,
   output logic                       wb_stb,
   output video_pkg::src_addr_t       wb_adr,
   input  wire video_pkg::pixel_t     wb_dat,
   input  wire                        wb_ack,
   output logic                       wr_en,
   output logic                       wr_bank,
   output video_pkg::src_x_t          wr_addr,
   output video_pkg::pixel_t          wr_data
);
   import video_pkg::*;

   fetch_state_t state;
   src_x_t       col;
   logic         last_col;

   // render_line holds steady for the whole fetch
   assign wb_adr   = src_addr_t'(render_line) * src_addr_t'(SRC_W) + src_addr_t'(col);
   assign last_col = (col == src_x_t'(SRC_W - 1));

   always_ff @(posedge vga_clk) begin
      if (!reset_n) begin
         state  <= FETCH_IDLE;
         col    <= '0;
         wb_cyc <= 1'b0;
         wb_stb <= 1'b0;
         wr_en  <= 1'b0;
      end else begin
         wr_en <= 1'b0;
         if (render_start) begin
            // A new request aborts any fetch still running
            state  <= FETCH_BUS;
            col    <= '0;
            wb_cyc <= 1'b1;
            wb_stb <= 1'b1;
         end else begin
            case (state)
               FETCH_BUS: begin
                  if (!wb_stb) begin
                     wb_cyc <= 1'b1;
                     wb_stb <= 1'b1;
                  end else if (wb_ack) begin
                     wb_cyc <= 1'b0;
                     wb_stb <= 1'b0;
                     wr_en  <= 1'b1;
                     if (last_col) begin
                        state <= FETCH_DONE;
                     end else begin
                        col <= col + 1'b1;
                     end
                  end
               end
               FETCH_DONE: begin
                  col   <= '0;
                  state <= FETCH_IDLE;
               end
               default: state <= FETCH_IDLE;
            endcase
         end
      end
   end

   // Write payload, qualified by wr_en
   always_ff @(posedge vga_clk) begin
      if (wb_stb && wb_ack) begin
         wr_data <= wb_dat;
         wr_addr <= col;
         wr_bank <= render_buffer;
      end
   end

endmodule

`default_nettype wire

// ==== src/line_buffer.sv ====
`default_nettype none

module line_buffer (
   input  wire                     vga_clk,
   input  wire                     wr_en,
   input  wire                     wr_bank,
   input  wire video_pkg::src_x_t  wr_addr,
   input  wire video_pkg::pixel_t  wr_data,
   input  wire                     rd_bank,
   input  wire video_pkg::src_x_t  rd_addr,
   output video_pkg::pixel_t       rd_data
);
   import video_pkg::*;

   // Bank select is the top address bit
   pixel_t mem [2*SRC_W];

   always_ff @(posedge vga_clk) begin
      if (wr_en) begin
         mem[{wr_bank, wr_addr}] <= wr_data;
      end
   end

   always_ff @(posedge vga_clk) begin
      rd_data <= mem[{rd_bank, rd_addr}];
   end

endmodule

`default_nettype wire

// ==== src/scan_out.sv ====
`default_nettype none

module scan_out (
   input  wire                      vga_clk,
   input  wire                      reset_n,
   input  wire video_pkg::h_count_t x_cnt,
   input  wire                      active,
   input  wire                      hsync_in,
   input  wire                      vsync_in,
   input  wire                      pf,
   input  wire                      output_buffer,
   output logic                     rd_bank,
   output video_pkg::src_x_t        rd_addr,
   input  wire video_pkg::pixel_t   rd_data,
   output video_pkg::pixel_t        rgb,
   output logic                     hsync,
   output logic                     vsync,
   output logic                     de
);
   import video_pkg::*;

   logic active_q;
   logic hsync_q;
   logic vsync_q;
   logic pf_q;

   assign rd_bank = output_buffer;

   // Each source pixel covers two output columns
   assign rd_addr = src_x_t'(x_cnt >> 1);

   // First stage lines up with the RAM read, second is the port register
   always_ff @(posedge vga_clk) begin
      if (!reset_n) begin
         active_q <= 1'b0;
         hsync_q  <= 1'b0;
         vsync_q  <= 1'b0;
         pf_q     <= 1'b0;
         de       <= 1'b0;
         hsync    <= 1'b0;
         vsync    <= 1'b0;
      end else begin
         active_q <= active;
         hsync_q  <= hsync_in;
         vsync_q  <= vsync_in;
         pf_q     <= pf;
         de       <= active_q;
         hsync    <= hsync_q;
         vsync    <= vsync_q;
      end
   end

   always_ff @(posedge vga_clk) begin
      if (active_q && pf_q) begin
         rgb <= rd_data;
      end else begin
         rgb <= BLANK_PIX;
      end
   end

endmodule

`default_nettype wire

// ==== src/scan_doubler_top.sv ====
`default_nettype none

module scan_doubler_top (
   input  wire                        vga_clk,
   input  wire                        reset_n,
   input  wire                        scale_x4,
   output wire                        wb_cyc,
   output wire                        wb_stb,
   output wire video_pkg::src_addr_t  wb_adr,
   input  wire video_pkg::pixel_t     wb_dat,
   input  wire                        wb_ack,
   output wire video_pkg::pixel_t     rgb,
   output wire                        hsync,
   output wire                        vsync,
   output wire                        de
);
   import video_pkg::*;

   wire h_count_t  x_cnt;
   wire v_count_t  y_cnt;
   wire            line_end;
   wire            active;
   wire            tim_hsync;
   wire            tim_vsync;
   wire            pf;
   wire            render_start;
   wire            render_buffer;
   wire src_line_t render_line;
   wire            output_buffer;
   wire            wr_en;
   wire            wr_bank;
   wire src_x_t    wr_addr;
   wire pixel_t    wr_data;
   wire            rd_bank;
   wire src_x_t    rd_addr;
   wire pixel_t    rd_data;

   video_timing u_timing (
      .vga_clk  (vga_clk),
      .reset_n  (reset_n),
      .x_cnt    (x_cnt),
      .y_cnt    (y_cnt),
      .line_end (line_end),
      .active   (active),
      .hsync    (tim_hsync),
      .vsync    (tim_vsync),
      .pf       (pf)
   );

   line_render u_render (
      .vga_clk       (vga_clk),
      .reset_n       (reset_n),
      .y_cnt         (y_cnt),
      .line_end      (line_end),
      .scale_x4      (scale_x4),
      .render_start  (render_start),
      .render_buffer (render_buffer),
      .render_line   (render_line),
      .output_buffer (output_buffer)
   );

   line_fetch u_fetch (
      .vga_clk       (vga_clk),
      .reset_n       (reset_n),
      .render_start  (render_start),
      .render_buffer (render_buffer),
      .render_line   (render_line),
      .wb_cyc        (wb_cyc),
      .wb_stb        (wb_stb),
      .wb_adr        (wb_adr),
      .wb_dat        (wb_dat),
      .wb_ack        (wb_ack),
      .wr_en         (wr_en),
      .wr_bank       (wr_bank),
      .wr_addr       (wr_addr),
      .wr_data       (wr_data)
   );

   line_buffer u_buffer (
      .vga_clk (vga_clk),
      .wr_en   (wr_en),
      .wr_bank (wr_bank),
      .wr_addr (wr_addr),
      .wr_data (wr_data),
      .rd_bank (rd_bank),
      .rd_addr (rd_addr),
      .rd_data (rd_data)
   );

   scan_out u_scan (
      .vga_clk       (vga_clk),
      .reset_n       (reset_n),
      .x_cnt         (x_cnt),
      .active        (active),
      .hsync_in      (tim_hsync),
      .vsync_in      (tim_vsync),
      .pf            (pf),
      .output_buffer (output_buffer),
      .rd_bank       (rd_bank),
      .rd_addr       (rd_addr),
      .rd_data       (rd_data),
      .rgb           (rgb),
      .hsync         (hsync),
      .vsync         (vsync),
      .de            (de)
   );

endmodule

`default_nettype wire

// ==== testbench/tb_scan_doubler.sv ====
`default_nettype none

module tb_scan_doubler;
   timeunit 1ns;
   timeprecision 100ps;

   import video_pkg::*;

   localparam int MAX_STEPS = 6;
   localparam int STEP_BASE = SRC_LINES * SRC_W;
   localparam int DATA_LEN  = STEP_BASE + 3 * MAX_STEPS;

   logic       vga_clk;
   logic       reset_n;
   logic       scale_x4;
   logic       wb_cyc;
   logic       wb_stb;
   src_addr_t  wb_adr;
   pixel_t     wb_dat;
   logic       wb_ack;
   pixel_t     rgb;
   logic       hsync;
   logic       vsync;
   logic       de;

   // Source image followed by the step list
   logic [7:0] tdata [0:DATA_LEN-1];

   int    max_wait;
   int    wait_left;
   logic  pending;
   logic  rst_seen;
   logic  scale_seen;
   logic  mode_q;
   logic  frame_ok;
   logic  in_frame;
   logic  vsync_d;
   logic  de_d;
   logic  hsync_exp;
   int    frame_idx;
   int    row_idx;
   int    col_idx;
   int    line_pos;
   int    skip_next;
   int    pixel_errors;
   int    timing_errors;
   string test_name;
   real   timeout_ns = 0.0;

   scan_doubler_top UUT (
      .vga_clk  (vga_clk),
      .reset_n  (reset_n),
      .scale_x4 (scale_x4),
      .wb_cyc   (wb_cyc),
      .wb_stb   (wb_stb),
      .wb_adr   (wb_adr),
      .wb_dat   (wb_dat),
      .wb_ack   (wb_ack),
      .rgb      (rgb),
      .hsync    (hsync),
      .vsync    (vsync),
      .de       (de)
   );

   initial vga_clk = 1'b0;
   always #4 vga_clk = ~vga_clk;

   // Reference picture straight from the source image
   function automatic pixel_t expected_pixel(input int row, input int col, input logic x4);
      int rep;
      int line;
      rep = x4 ? 4 : 2;
      if (row < V_PF_START || row >= V_PF_END) begin
         return BLANK_PIX;
      end
      line = (row - V_PF_START) / rep;
      return tdata[line * SRC_W + col / 2];
   endfunction

   // Reset and mode as the DUT sampled them
   always @(posedge vga_clk) begin
      rst_seen   <= reset_n;
      scale_seen <= scale_x4;
   end

   // Wishbone slave with a random wait per read
   always @(negedge vga_clk) begin
      if (!rst_seen) begin
         wb_ack  = 1'b0;
         pending = 1'b0;
      end else if (wb_ack) begin
         wb_ack  = 1'b0;
         pending = 1'b0;
      end else if (wb_cyc && wb_stb) begin
         if (!pending) begin
            pending   = 1'b1;
            wait_left = $urandom_range(max_wait, 0);
         end
         if (wait_left == 0) begin
            wb_ack = 1'b1;
            wb_dat = tdata[wb_adr];
         end else begin
            wait_left--;
         end
      end
   end

   // Frame capture and checks
   always @(negedge vga_clk) begin
      if (!rst_seen) begin
         vsync_d  = 1'b0;
         de_d     = 1'b0;
         in_frame = 1'b0;
         frame_ok = 1'b0;
         row_idx  = -1;
         col_idx  = 0;
         line_pos = 0;
         mode_q   = scale_seen;
      end else begin
         if (scale_seen != mode_q) begin
            mode_q    = scale_seen;
            frame_ok  = 1'b0;
            skip_next = 1;
         end
         if (vsync && !vsync_d) begin
            if (in_frame && frame_ok && row_idx != V_TOTAL - 1) begin
               timing_errors++;
               $display("CHECK FAILED %s: rows in frame %0d expected %0d actual %0d",
                        test_name, frame_idx, V_TOTAL, row_idx + 1);
            end
            in_frame = 1'b1;
            frame_idx++;
            row_idx  = -1;
            frame_ok = (skip_next == 0);
            if (skip_next > 0) begin
               skip_next--;
            end
         end
         if (de && !de_d) begin
            row_idx++;
            col_idx  = 0;
            line_pos = 0;
         end
         // Sync window counted from the first visible pixel of the line
         hsync_exp = (line_pos >= H_SYNC_START) && (line_pos < H_SYNC_END);
         if (in_frame && hsync !== hsync_exp) begin
            timing_errors++;
            $display("CHECK FAILED %s: hsync in row %0d clock %0d expected %0b actual %0b",
                     test_name, row_idx, line_pos, hsync_exp, hsync);
         end
         if (!de && de_d && in_frame && col_idx != H_ACTIVE) begin
            timing_errors++;
            $display("CHECK FAILED %s: de clocks in row %0d expected %0d actual %0d",
                     test_name, row_idx, H_ACTIVE, col_idx);
         end
         if (de) begin
            if (in_frame && frame_ok && rgb !== expected_pixel(row_idx, col_idx, mode_q)) begin
               pixel_errors++;
               $display("CHECK FAILED %s: frame %0d row %0d col %0d expected %02h actual %02h",
                        test_name, frame_idx, row_idx, col_idx,
                        expected_pixel(row_idx, col_idx, mode_q), rgb);
            end
            col_idx++;
         end else if (rgb !== BLANK_PIX) begin
            pixel_errors++;
            $display("CHECK FAILED %s: blanking in row %0d expected %02h actual %02h",
                     test_name, row_idx, BLANK_PIX, rgb);
         end
         vsync_d = vsync;
         de_d    = de;
         line_pos++;
      end
   end

   initial begin
      int   step;
      int   frames;
      int   total_frames;
      logic step_x4;
      reset_n       = 1'b0;
      scale_x4      = 1'b0;
      wb_dat        = '0;
      wb_ack        = 1'b0;
      max_wait      = 0;
      wait_left     = 0;
      pending       = 1'b0;
      frame_idx     = 0;
      skip_next     = 1;
      pixel_errors  = 0;
      timing_errors = 0;
      test_name     = "reset";
      void'($urandom(41468));
      $readmemh("testbench/scan_testdata.txt", tdata);
      total_frames = 0;
      for (step = 0; step < MAX_STEPS; step++) begin
         total_frames += tdata[STEP_BASE + 3 * step + 1];
      end
      timeout_ns = total_frames * V_TOTAL * H_TOTAL * 8.0 * 1.5 + 8 * 8.0;
      scale_x4 = tdata[STEP_BASE][0];
      repeat (8) @(negedge vga_clk);
      reset_n = 1'b1;
      for (step = 0; step < MAX_STEPS; step++) begin
         frames = tdata[STEP_BASE + 3 * step + 1];
         if (frames == 0) begin
            break;
         end
         step_x4   = tdata[STEP_BASE + 3 * step][0];
         max_wait  = tdata[STEP_BASE + 3 * step + 2];
         test_name = $sformatf("step%0d_x%0d_wait%0d", step, step_x4 ? 4 : 2, max_wait);
         // Mode change lands in the middle of a frame
         if (step_x4 != scale_x4) begin
            wait (row_idx == 10);
            @(negedge vga_clk);
            scale_x4 = step_x4;
         end
         repeat (frames) @(posedge vsync);
      end
      // Let the row count check of the last frame run first
      repeat (2) @(negedge vga_clk);
      $display("Checks finished: %0d pixel errors, %0d timing errors",
               pixel_errors, timing_errors);
      if (pixel_errors + timing_errors == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

   initial begin
      wait (timeout_ns > 0.0);
      #(timeout_ns);
      $display("ERROR: run timed out before all test steps finished");
      $display("Simulation FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== testbench/scan_testdata.txt ====
// Source image: 16 lines of 16 pixels, byte at address a is a ^ 8'hA5
// Then test steps, one per line: scale_x4, frame count, max slave wait (00 frames ends)
A5 A4 A7 A6 A1 A0 A3 A2 AD AC AF AE A9 A8 AB AA
B5 B4 B7 B6 B1 B0 B3 B2 BD BC BF BE B9 B8 BB BA
85 84 87 86 81 80 83 82 8D 8C 8F 8E 89 88 8B 8A
95 94 97 96 91 90 93 92 9D 9C 9F 9E 99 98 9B 9A
E5 E4 E7 E6 E1 E0 E3 E2 ED EC EF EE E9 E8 EB EA
F5 F4 F7 F6 F1 F0 F3 F2 FD FC FF FE F9 F8 FB FA
C5 C4 C7 C6 C1 C0 C3 C2 CD CC CF CE C9 C8 CB CA
D5 D4 D7 D6 D1 D0 D3 D2 DD DC DF DE D9 D8 DB DA
25 24 27 26 21 20 23 22 2D 2C 2F 2E 29 28 2B 2A
35 34 37 36 31 30 33 32 3D 3C 3F 3E 39 38 3B 3A
05 04 07 06 01 00 03 02 0D 0C 0F 0E 09 08 0B 0A
15 14 17 16 11 10 13 12 1D 1C 1F 1E 19 18 1B 1A
65 64 67 66 61 60 63 62 6D 6C 6F 6E 69 68 6B 6A
75 74 77 76 71 70 73 72 7D 7C 7F 7E 79 78 7B 7A
45 44 47 46 41 40 43 42 4D 4C 4F 4E 49 48 4B 4A
55 54 57 56 51 50 53 52 5D 5C 5F 5E 59 58 5B 5A
// Test steps
00 04 00
00 03 03
01 03 00
01 03 03
00 03 02
00 00 00

// ==== verilog.f ====
src/video_pkg.sv
src/video_timing.sv
src/line_render.sv
src/line_fetch.sv
src/line_buffer.sv
src/scan_out.sv
src/scan_doubler_top.sv
testbench/tb_scan_doubler.sv

// ==== Bender.yml ====
package:
  name: scan_doubler

sources:
  - src/video_pkg.sv
  - src/video_timing.sv
  - src/line_render.sv
  - src/line_fetch.sv
  - src/line_buffer.sv
  - src/scan_out.sv
  - src/scan_doubler_top.sv
  - target: test
    files:
      - testbench/tb_scan_doubler.sv
